//--- build.f
hdl/int_ctrl_pkg.sv
hdl/int_status_bank.sv
hdl/int_arbiter.sv
hdl/int_ctrl_top.sv
test/tb_clock.sv
test/int_ctrl_properties.sv
test/int_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Build the interrupt controller simulation with Verilator and run it
# The exit status of the simulation is the exit status of this script
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module int_ctrl_tb \
    -f build.f \
    -o int_ctrl_sim

./obj_dir/int_ctrl_sim

//--- test/int_ctrl_tb.sv
// Testbench driving the interrupt controller and checking it against a reference model
`timescale 1ns/10ps

module int_ctrl_tb import int_ctrl_pkg::*; ();

    localparam int DW            = 16;
    localparam int RESET_CYCLES  = 3;
    localparam int RANDOM_CYCLES = 400;
    localparam int WAIT_LIMIT    = 20;
    localparam int CLEAR_LIMIT   = 40;

    // DUT connections
    logic                    clk;
    logic                    rst_n;
    logic [DW-1:0]           int_src_hi;
    logic [DW-1:0]           int_src_lo;
    logic                    valid_in;
    logic                    ack;
    logic                    valid_out;
    logic                    irq;
    logic                    irq_hi;
    logic [id_width(DW)-1:0] irq_id;
    logic [DW-1:0]           status_hi;
    logic [DW-1:0]           status_lo;

    int seed;

    // Model stage driven before the next edge
    logic [DW-1:0] drv_hi;
    logic [DW-1:0] drv_lo;
    logic          drv_valid;
    logic          drv_ack_hi;
    logic          drv_ack_lo;
    logic          drv_strobe;
    // Model stage sampled on the last edge
    logic [DW-1:0] pend_hi;
    logic [DW-1:0] pend_lo;
    logic          pend_valid;
    logic          pend_ack_hi;
    logic          pend_ack_lo;
    logic          pend_strobe;
    // Model bank contents and what the outputs show
    logic [DW-1:0] bank_hi;
    logic [DW-1:0] bank_lo;
    logic          bank_upd;
    logic [DW-1:0] vis_hi;
    logic [DW-1:0] vis_lo;
    logic          vis_valid;

    tb_clock #(
        .PERIOD (8)
    ) u_clock (
        .clk (clk)
    );

    int_ctrl_top #(
        .DW (DW)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .int_src_hi (int_src_hi),
        .int_src_lo (int_src_lo),
        .valid_in   (valid_in),
        .ack        (ack),
        .valid_out  (valid_out),
        .irq        (irq),
        .irq_hi     (irq_hi),
        .irq_id     (irq_id),
        .status_hi  (status_hi),
        .status_lo  (status_lo)
    );

    task report_error(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Errors found");
        $fatal(1, "Stopped on a timeout");
    endtask

    // Lowest set bit position found by shifting right
    function automatic int first_pending(input logic [DW-1:0] vec);
        logic [DW-1:0] rest;
        int            k;
        rest = vec;
        k    = 0;
        while (rest != '0 && !rest[0]) begin
            rest = rest >> 1;
            k++;
        end
        return k;
    endfunction

    // Bank rule where an acknowledge keeps only the freshly sampled sources
    function automatic logic [DW-1:0] apply_update(
        input logic [DW-1:0] old,
        input logic [DW-1:0] src,
        input logic          v,
        input logic          a
    );
        logic [DW-1:0] sampled;
        sampled = v ? src : '0;
        if (a) begin
            return sampled;
        end
        return old | sampled;
    endfunction

    function void clear_model();
        {drv_hi, drv_lo, drv_valid, drv_ack_hi, drv_ack_lo, drv_strobe} = '0;
        {pend_hi, pend_lo, pend_valid, pend_ack_hi, pend_ack_lo, pend_strobe} = '0;
        {bank_hi, bank_lo, bank_upd} = '0;
        {vis_hi, vis_lo, vis_valid} = '0;
    endfunction

    // One clock edge of the model with the stages moved from the back
    function void advance_model();
        vis_hi      = bank_hi;
        vis_lo      = bank_lo;
        vis_valid   = bank_upd;
        bank_upd    = pend_strobe;
        bank_hi     = apply_update(bank_hi, pend_hi, pend_valid, pend_ack_hi);
        bank_lo     = apply_update(bank_lo, pend_lo, pend_valid, pend_ack_lo);
        pend_hi     = drv_hi;
        pend_lo     = drv_lo;
        pend_valid  = drv_valid;
        pend_ack_hi = drv_ack_hi;
        pend_ack_lo = drv_ack_lo;
        pend_strobe = drv_strobe;
    endfunction

    task check_outputs();
        logic       exp_irq;
        int_class_e exp_class;
        int         exp_id;
        exp_irq = (|vis_hi) || (|vis_lo);
        if (|vis_hi) begin
            exp_class = CLASS_HI;
            exp_id    = first_pending(vis_hi);
        end else begin
            exp_class = CLASS_LO;
            exp_id    = first_pending(vis_lo);
        end
        assert (valid_out === vis_valid) else
            report_error($sformatf("valid_out %b, expected %b", valid_out, vis_valid));
        assert (status_hi === vis_hi) else
            report_error($sformatf("status_hi %h, expected %h", status_hi, vis_hi));
        assert (status_lo === vis_lo) else
            report_error($sformatf("status_lo %h, expected %h", status_lo, vis_lo));
        assert (irq === exp_irq) else
            report_error($sformatf("irq %b, expected %b", irq, exp_irq));
        assert (irq_hi === (exp_class == CLASS_HI)) else
            report_error($sformatf("irq_hi %b, expected class %s", irq_hi, exp_class.name()));
        // Index only means something while an interrupt is raised
        if (exp_irq) begin
            assert (int'(irq_id) == exp_id) else
                report_error($sformatf("irq_id %0d, expected %0d", irq_id, exp_id));
        end
    endtask

    // On the falling edge check the last rising edge and drive new inputs
    task run_cycle(
        input logic          v,
        input logic          a,
        input logic [DW-1:0] s_hi,
        input logic [DW-1:0] s_lo
    );
        logic vis_irq;
        @(negedge clk);
        advance_model();
        check_outputs();
        vis_irq    = (|vis_hi) || (|vis_lo);
        valid_in   = v;
        ack        = a;
        int_src_hi = s_hi;
        int_src_lo = s_lo;
        drv_hi     = s_hi;
        drv_lo     = s_lo;
        drv_valid  = v;
        // Acknowledge goes to the class the outputs show right now
        drv_ack_hi = a && vis_irq && (|vis_hi);
        drv_ack_lo = a && vis_irq && !(|vis_hi);
        drv_strobe = v || a;
    endtask

    task idle_cycle();
        run_cycle(1'b0, 1'b0, '0, '0);
    endtask

    // Sparse sources with the high class sparser still
    task random_cycle();
        logic [31:0] r;
        logic [31:0] bits_hi;
        logic [31:0] bits_lo;
        r       = $random(seed);
        bits_hi = $random(seed) & $random(seed) & $random(seed) & $random(seed);
        bits_lo = $random(seed) & $random(seed) & $random(seed);
        run_cycle(r[1:0] == 2'b00, r[3:2] == 2'b00, bits_hi[DW-1:0], bits_lo[DW-1:0]);
    endtask

    task wait_valid_out();
        int n;
        n = 1;
        idle_cycle();
        while (valid_out !== 1'b1 && n < WAIT_LIMIT) begin
            idle_cycle();
            n++;
        end
        if (valid_out !== 1'b1) begin
            report_timeout("valid_out did not follow the last strobe");
        end
    endtask

    // Acknowledge until nothing is pending
    task clear_pending();
        int n;
        n = 0;
        while (irq === 1'b1 && n < CLEAR_LIMIT) begin
            run_cycle(1'b0, 1'b1, '0, '0);
            wait_valid_out();
            n++;
        end
        if (irq !== 1'b0) begin
            report_timeout("irq stayed high through repeated acknowledges");
        end
    endtask

    initial begin
        seed        = 32'hcd58_45f5;
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        ack         = 1'b0;
        int_src_hi  = '0;
        int_src_lo  = '0;
        clear_model();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        // Outputs quiet before any strobe
        repeat (4) idle_cycle();
        // Acknowledge with nothing pending
        run_cycle(1'b0, 1'b1, '0, '0);
        wait_valid_out();
        // Back-to-back sets accumulate
        run_cycle(1'b1, 1'b0, DW'(8'h24), DW'(8'h50));
        run_cycle(1'b1, 1'b0, DW'(8'h01), DW'(8'h08));
        wait_valid_out();
        wait_valid_out();
        // High class served while a new high bit survives its own acknowledge
        run_cycle(1'b1, 1'b1, DW'(8'h80), DW'(8'h02));
        wait_valid_out();
        run_cycle(1'b0, 1'b1, '0, '0);
        wait_valid_out();
        // Low class served next with a fresh low bit kept
        run_cycle(1'b1, 1'b1, '0, DW'(8'h40));
        wait_valid_out();
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            random_cycle();
        end
        // Let strobes in flight land before clearing
        repeat (3) idle_cycle();
        clear_pending();
        repeat (3) idle_cycle();
        $display("No errors");
        $finish;
    end

endmodule

//--- test/int_ctrl_properties.sv
// Concurrent timing and consistency checks for the interrupt controller top level
`timescale 1ns/10ps

module int_ctrl_properties import int_ctrl_pkg::*; #(
    parameter int DW = 16
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    valid_in,
    input logic                    ack,
    input logic                    valid_out,
    input logic                    irq,
    input logic                    irq_hi,
    input logic [id_width(DW)-1:0] irq_id,
    input logic [DW-1:0]           status_hi,
    input logic [DW-1:0]           status_lo
);

    // One valid_out per strobe exactly three edges after it was sampled
    // Also rules out a valid_out with no strobe behind it
    a_valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_out == $past(valid_in || ack, 3)
    ) else $error("valid_out out of step with the strobes three edges earlier");

    // irq follows the registered status copies
    a_irq_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        irq == ((|status_hi) || (|status_lo))
    ) else $error("irq disagrees with the pending status");

    // High class served exactly while a high bit is pending
    a_irq_hi_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        irq_hi == (|status_hi)
    ) else $error("irq_hi disagrees with the high status");

    // Index names a pending bit of the served class
    a_irq_id_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        irq |-> (irq_hi ? status_hi[irq_id] : status_lo[irq_id])
    ) else $error("irq_id points at a bit that is not pending");

    // Status outputs only move in a valid_out cycle
    a_status_quiet: assert property (
        @(posedge clk) disable iff (!rst_n)
        !valid_out |-> ($stable(status_hi) && $stable(status_lo))
    ) else $error("status changed without valid_out");

endmodule

// Attach the checks to every controller top level
bind int_ctrl_top int_ctrl_properties #(
    .DW (DW)
) u_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (valid_in),
    .ack       (ack),
    .valid_out (valid_out),
    .irq       (irq),
    .irq_hi    (irq_hi),
    .irq_id    (irq_id),
    .status_hi (status_hi),
    .status_lo (status_lo)
);

//--- test/tb_clock.sv
// Testbench clock generator with a free-running clock of configurable period
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    // Starts low with the first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- hdl/int_ctrl_top.sv
// Two-class interrupt controller top level joining both status banks to the arbiter
`timescale 1ns/10ps

module int_ctrl_top import int_ctrl_pkg::*; #(
    parameter int DW = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [DW-1:0]           int_src_hi,
    input  logic [DW-1:0]           int_src_lo,
    input  logic                    valid_in,
    input  logic                    ack,
    output logic                    valid_out,
    output logic                    irq,
    output logic                    irq_hi,
    output logic [id_width(DW)-1:0] irq_id,
    output logic [DW-1:0]           status_hi,
    output logic [DW-1:0]           status_lo
);

    // High bank link
    logic [DW-1:0] bank_status_hi;
    logic          bank_update_hi;
    logic          ack_hi;

    // Low bank link
    logic [DW-1:0] bank_status_lo;
    logic          bank_update_lo;
    logic          ack_lo;

    // High-priority sources
    int_status_bank #(
        .DW (DW)
    ) u_bank_hi (
        .clk    (clk),
        .rst_n  (rst_n),
        .src    (int_src_hi),
        .valid  (valid_in),
        .ack    (ack_hi),
        .status (bank_status_hi),
        .update (bank_update_hi)
    );

    // Normal-priority sources
    // Same valid_in as the high bank, so both update on the same edge
    int_status_bank #(
        .DW (DW)
    ) u_bank_lo (
        .clk    (clk),
        .rst_n  (rst_n),
        .src    (int_src_lo),
        .valid  (valid_in),
        .ack    (ack_lo),
        .status (bank_status_lo),
        .update (bank_update_lo)
    );

    // Selection, acknowledge steering and output stage
    int_arbiter #(
        .DW (DW)
    ) u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .ack         (ack),
        .status_hi   (bank_status_hi),
        .status_lo   (bank_status_lo),
        .update_hi   (bank_update_hi),
        .update_lo   (bank_update_lo),
        .ack_hi      (ack_hi),
        .ack_lo      (ack_lo),
        .irq         (irq),
        .irq_hi      (irq_hi),
        .irq_id      (irq_id),
        .valid_out   (valid_out),
        .status_hi_q (status_hi),
        .status_lo_q (status_lo)
    );

endmodule

//--- hdl/int_arbiter.sv
// Fixed-priority arbiter across both banks with acknowledge routing and output registers
`timescale 1ns/10ps

module int_arbiter import int_ctrl_pkg::*; #(
    parameter int DW = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ack,
    input  logic [DW-1:0]           status_hi,
    input  logic [DW-1:0]           status_lo,
    input  logic                    update_hi,
    input  logic                    update_lo,
    output logic                    ack_hi,
    output logic                    ack_lo,
    output logic                    irq,
    output logic                    irq_hi,
    output logic [id_width(DW)-1:0] irq_id,
    output logic                    valid_out,
    output logic [DW-1:0]           status_hi_q,
    output logic [DW-1:0]           status_lo_q
);

    localparam int IW = id_width(DW);

    // Combinational selection
    logic          pend_hi;
    logic          pend_lo;
    logic [IW-1:0] idx_hi;
    logic [IW-1:0] idx_lo;
    logic [IW-1:0] sel_id;
    int_class_e    sel_class;

    // Registered result written on edge N+2
    logic          irq_q;
    int_class_e    class_q;
    logic [IW-1:0] id_q;
    logic          valid_q;
    logic [DW-1:0] stat_hi_q;
    logic [DW-1:0] stat_lo_q;

    // Acknowledges that find nothing served
    logic          ack_idle;
    logic          ack_idle_q1;
    logic          ack_idle_q2;

    // Lowest set index of a bank
    // Scans downward so the last hit is the lowest bit
    function automatic logic [IW-1:0] lowest_set(input logic [DW-1:0] vec);
        logic [IW-1:0] idx;
        idx = '0;
        for (int i = DW - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IW'(i);
            end
        end
        return idx;
    endfunction

    assign pend_hi = |status_hi;
    assign pend_lo = |status_lo;
    assign idx_hi  = lowest_set(status_hi);
    assign idx_lo  = lowest_set(status_lo);

    // High bank wins whenever anything is pending there
    assign sel_class = class_of(pend_hi);
    assign sel_id    = (sel_class == CLASS_HI) ? idx_hi : idx_lo;

    // Acknowledge goes to the class on the registered outputs
    // With irq low it reaches neither bank
    assign ack_hi   = ack & irq_q & (class_q == CLASS_HI);
    assign ack_lo   = ack & irq_q & (class_q == CLASS_LO);
    assign ack_idle = ack & ~irq_q;

    // Dropped acknowledges still owe a valid_out
    // Two stages line them up with the bank update pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_idle_q1 <= 1'b0;
            ack_idle_q2 <= 1'b0;
        end else begin
            ack_idle_q1 <= ack_idle;
            ack_idle_q2 <= ack_idle_q1;
        end
    end

    // Output registers
    // Both banks pulse update on the same edge for a shared valid_in, so OR gives one strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q     <= 1'b0;
            class_q   <= CLASS_LO;
            id_q      <= '0;
            valid_q   <= 1'b0;
            stat_hi_q <= '0;
            stat_lo_q <= '0;
        end else begin
            irq_q     <= pend_hi | pend_lo;
            class_q   <= sel_class;
            id_q      <= sel_id;
            valid_q   <= update_hi | update_lo | ack_idle_q2;
            stat_hi_q <= status_hi;
            stat_lo_q <= status_lo;
        end
    end

    assign irq         = irq_q;
    assign irq_hi      = (class_q == CLASS_HI);
    assign irq_id      = id_q;
    assign valid_out   = valid_q;
    assign status_hi_q = stat_hi_q;
    assign status_lo_q = stat_lo_q;

endmodule

//--- hdl/int_status_bank.sv
// Pending-status bank for one priority class, set by sources and auto-cleared on acknowledge
`timescale 1ns/10ps

module int_status_bank #(
    parameter int DW = 16
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic [DW-1:0] src,
    input  logic          valid,
    input  logic          ack,
    output logic [DW-1:0] status,
    output logic          update
);

    // Input stage sampled on edge N
    logic [DW-1:0] src_q;
    logic          valid_q;
    logic          ack_q;

    // Status stage written on edge N+1
    logic [DW-1:0] status_q;
    logic          update_q;

    // Combinational update terms
    logic [DW-1:0] new_bits;
    logic [DW-1:0] kept_bits;
    logic [DW-1:0] status_next;

    // Source payload
    // Qualified by valid_q further down
    always_ff @(posedge clk) begin
        src_q <= src;
    end

    // Strobes of the input stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            valid_q <= valid;
            ack_q   <= ack;
        end
    end

    // Sources only count when the strobe came with them
    assign new_bits = valid_q ? src_q : '0;

    // Acknowledge drops everything pending before this update
    assign kept_bits = ack_q ? '0 : status_q;

    // Bits sampled in the same update as an acknowledge survive the clear
    assign status_next = kept_bits | new_bits;

    // Status register
    // Held when neither strobe was sampled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= '0;
        end else if (valid_q || ack_q) begin
            status_q <= status_next;
        end
    end

    // One update pulse per sampled strobe
    // High in the cycle after edge N+1 together with the new status
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            update_q <= 1'b0;
        end else begin
            update_q <= valid_q | ack_q;
        end
    end

    assign status = status_q;
    assign update = update_q;

endmodule

//--- hdl/int_ctrl_pkg.sv
// Interrupt controller package with the priority class type and index width helper
package int_ctrl_pkg;

    // Class of the interrupt currently served
    // One bit wide, so the class doubles as a high-priority flag
    typedef enum logic {
        CLASS_LO = 1'b0,
        CLASS_HI = 1'b1
    } int_class_e;

    // Number of index bits needed to name one source in a bank of w sources
    // A single-source bank still gets one bit so the index port never collapses
    function automatic int id_width(input int w);
        int bits;
        bits = 1;
        if (w > 2) begin
            bits = $clog2(w);
        end
        return bits;
    endfunction

    // Class from a high-bank-pending flag
    function automatic int_class_e class_of(input logic hi_pending);
        int_class_e cls;
        cls = CLASS_LO;
        if (hi_pending) begin
            cls = CLASS_HI;
        end
        return cls;
    endfunction

endpackage
